// File: common/spi_memory_settings.svh
/*
 * Width and timing constants for the SPI slave memory.
 * Address plus read/write flag must fill exactly one data byte.
 */
`ifndef SPI_MEMORY_SETTINGS_SVH
`define SPI_MEMORY_SETTINGS_SVH

// --------------------
// Bus widths
// --------------------
`define SPI_ADDR_WIDTH 7                  // 128-byte memory
`define SPI_DATA_WIDTH 8                  // One byte per transfer

// --------------------
// Input conditioner
// --------------------
`define COND_WAIT_TIME 3                  // Stable clk cycles before level follows
`define COND_COUNT_WIDTH 2                // Must hold COND_WAIT_TIME - 1

`endif

// File: common/spi_memory_pkg.sv
/*
 * Shared types for the SPI slave memory.
 * State order matters only for debug printing.
 */
`include "spi_memory_settings.svh"

package spi_memory_pkg;

    // --------------------
    // Payload types
    // --------------------
    typedef logic [`SPI_DATA_WIDTH-1:0] spi_byte_t;   // Shift register and memory word
    typedef logic [`SPI_ADDR_WIDTH-1:0] spi_addr_t;   // Memory index

    // --------------------
    // Protocol states
    // --------------------
    typedef enum logic [2:0] {
        idle,           // Waiting for cs low
        get_address,    // Shifting address and flag
        latch_address,  // Address into memory latch
        read_load,      // Memory byte into shift register
        read_shift,     // Driving miso until cs rises
        write_shift,    // Shifting write data
        write_commit,   // Memory write strobe
        done            // Waiting for cs high
    } spi_state_t;

endpackage

// File: source/input_conditioner.sv
/*
 * Synchronizes and debounces one asynchronous pin.
 * Latency is 2 + COND_WAIT_TIME clk cycles; reset level is 0.
 */
`timescale 1ns/1ps
`include "spi_memory_settings.svh"

module input_conditioner (
    input  logic clk,
    input  logic reset,
    input  logic noisy,         // Raw pin
    output logic conditioned,   // Clean level
    output logic rising_edge,   // One cycle, with the 0 to 1 change
    output logic falling_edge   // One cycle, with the 1 to 0 change
);
    logic                         sync_0;
    logic                         sync_1;
    logic [`COND_COUNT_WIDTH-1:0] stable_count;

    // Two-flop synchronizer
    always_ff @(posedge clk) begin
        sync_0 <= noisy;
        sync_1 <= sync_0;
    end

    // --------------------
    // Debounce counter
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            conditioned  <= 1'b0;
            rising_edge  <= 1'b0;
            falling_edge <= 1'b0;
            stable_count <= '0;
        end else begin
            rising_edge  <= 1'b0;
            falling_edge <= 1'b0;
            if (sync_1 == conditioned) begin
                stable_count <= '0;                 // Glitch over, start again
            end else if (stable_count == `COND_COUNT_WIDTH'(`COND_WAIT_TIME - 1)) begin
                conditioned  <= sync_1;             // Held long enough
                rising_edge  <= sync_1;
                falling_edge <= !sync_1;
                stable_count <= '0;
            end else begin
                stable_count <= stable_count + 1'b1;
            end
        end
    end

    // New level seen on three samples in a row, as COND_WAIT_TIME is 3
    a_filtered_change : assert property (@(posedge clk) disable iff (reset)
        (conditioned != $past(conditioned)) |->
            ($past(sync_1, 1) == conditioned) && ($past(sync_1, 2) == conditioned)
            && ($past(sync_1, 3) == conditioned));

endmodule

// File: source/shift_register.sv
/*
 * 8-bit shift register with a registered MISO bit.
 * Load wins over shift, shift wins over the MISO update.
 */
`timescale 1ns/1ps

module shift_register
    import spi_memory_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      shift_en,      // Take serial_in on the right
    input  logic      serial_in,     // Conditioned mosi
    input  logic      load_en,       // Take parallel_in
    input  spi_byte_t parallel_in,   // Memory read byte
    input  logic      miso_update,   // Top bit out to miso
    output spi_byte_t parallel_out,
    output logic      miso
);
    spi_byte_t shift_reg;

    assign parallel_out = shift_reg;

    // --------------------
    // Data path
    // --------------------
    always_ff @(posedge clk) begin
        if (load_en) begin
            shift_reg <= parallel_in;
        end else if (shift_en) begin
            shift_reg <= {shift_reg[$bits(spi_byte_t)-2:0], serial_in};   // MSB first
        end else if (miso_update) begin
            shift_reg <= {shift_reg[$bits(spi_byte_t)-2:0], 1'b0};
        end
    end

    // MISO output flop, changes only on the SCLK falling pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            miso <= 1'b0;
        end else if (miso_update && !load_en && !shift_en) begin
            miso <= shift_reg[$bits(spi_byte_t)-1];
        end
    end

    a_load_shift_exclusive : assert property (@(posedge clk) disable iff (reset)
        !(load_en && shift_en));

endmodule

// File: source/data_memory.sv
/*
 * 128-byte memory with its own address latch.
 * Read is combinational from the latched address; contents are not reset.
 */
`timescale 1ns/1ps
`include "spi_memory_settings.svh"

module data_memory
    import spi_memory_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      addr_we,      // Latch addr_in
    input  spi_addr_t addr_in,      // Upper seven bits of the first byte
    input  logic      mem_we,       // Write at latched address
    input  spi_byte_t write_data,
    output spi_byte_t read_data
);
    localparam int DEPTH = 2 ** `SPI_ADDR_WIDTH;

    spi_addr_t addr_q;
    spi_byte_t mem [DEPTH];

    // --------------------
    // Address latch
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (addr_we) begin
            addr_q <= addr_in;
        end
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[addr_q] <= write_data;
        end
    end

    assign read_data = mem[addr_q];   // Ready one cycle after addr_we

endmodule

// File: source/spi_protocol_fsm.sv
/*
 * SPI mode 0 protocol control, one byte per transaction.
 * Strobes decode from state and the sclk pulses; cs high aborts at once.
 */
`timescale 1ns/1ps
`include "spi_memory_settings.svh"

module spi_protocol_fsm
    import spi_memory_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic sclk_rise,     // Conditioned sclk edges
    input  logic sclk_fall,
    input  logic cs_level,      // Conditioned cs, active low
    input  logic rw_flag,       // Bit 0 of the shift register, 1 = read
    output logic shift_en,
    output logic addr_we,
    output logic load_en,
    output logic mem_we,
    output logic miso_update,
    output logic miso_oe
);
    localparam int FRAME_BITS  = `SPI_ADDR_WIDTH + 1;               // Address plus flag
    localparam int TOTAL_BITS  = FRAME_BITS + `SPI_DATA_WIDTH;
    localparam int COUNT_WIDTH = $clog2(TOTAL_BITS + 1);

    spi_state_t             state;
    spi_state_t             next_state;
    logic [COUNT_WIDTH-1:0] bit_count;    // SCLK edges seen in this transaction
    logic                   receiving;

    // --------------------
    // Strobe decode
    // --------------------
    assign receiving   = (state == get_address) || (state == write_shift);
    assign shift_en    = receiving && sclk_rise;
    assign addr_we     = (state == latch_address);
    assign load_en     = (state == read_load);
    assign mem_we      = (state == write_commit);
    assign miso_update = (state == read_shift) && sclk_fall
                         && (bit_count < COUNT_WIDTH'(TOTAL_BITS));  // Eight bits only
    assign miso_oe     = (state == read_load) || (state == read_shift);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (!cs_level) begin
                    next_state = get_address;
                end
            end
            get_address: begin
                if (shift_en && bit_count == COUNT_WIDTH'(FRAME_BITS - 1)) begin
                    next_state = latch_address;       // Flag is now in bit 0
                end
            end
            latch_address: next_state = rw_flag ? read_load : write_shift;
            read_load:     next_state = read_shift;
            read_shift:    next_state = read_shift;   // Hold miso until cs rises
            write_shift: begin
                if (shift_en && bit_count == COUNT_WIDTH'(TOTAL_BITS - 1)) begin
                    next_state = write_commit;
                end
            end
            write_commit:  next_state = done;
            done:          next_state = done;
            default:       next_state = idle;
        endcase
        if (cs_level) begin
            next_state = idle;                        // Abort, nothing written
        end
    end

    // State and bit counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            bit_count <= '0;
        end else begin
            state <= next_state;
            if (state == idle) begin
                bit_count <= '0;
            end else if (shift_en || miso_update) begin
                bit_count <= bit_count + 1'b1;
            end
        end
    end

    // Load right after the latch, with the read flag still in place
    a_load_after_read_flag : assert property (@(posedge clk) disable iff (reset)
        load_en |-> $past(addr_we) && rw_flag);

    // Raised cs frees the pad and blocks the commit
    a_cs_abort : assert property (@(posedge clk) disable iff (reset)
        $past(cs_level) |-> !miso_oe && !mem_we);

endmodule

// File: source/spi_memory.sv
/*
 * SPI mode 0 slave memory, 7-bit address then flag then one data byte.
 * miso is valid only while miso_oe is high; no tristate inside.
 */
`timescale 1ns/1ps

module spi_memory
    import spi_memory_pkg::*;
(
    input  logic clk,         // FPGA clock
    input  logic reset,
    input  logic sclk,        // Asynchronous SPI pins
    input  logic cs,
    input  logic mosi,
    output logic miso,
    output logic miso_oe      // Pad enable for miso
);
    localparam int MOSI_IDX = 0;
    localparam int SCLK_IDX = 1;
    localparam int CS_IDX   = 2;
    localparam int NUM_PINS = 3;

    logic [NUM_PINS-1:0] pins;
    logic [NUM_PINS-1:0] cond_level;
    logic [NUM_PINS-1:0] cond_rise;
    logic [NUM_PINS-1:0] cond_fall;

    logic      shift_en;
    logic      addr_we;
    logic      load_en;
    logic      mem_we;
    logic      miso_update;
    spi_byte_t parallel_out;
    spi_byte_t read_data;

    assign pins = {cs, sclk, mosi};   // Order matches the *_IDX values

    // --------------------
    // Pin conditioning
    // --------------------
    for (genvar i = 0; i < NUM_PINS; i++) begin : g_cond
        input_conditioner u_cond (
            .clk          (clk),
            .reset        (reset),
            .noisy        (pins[i]),
            .conditioned  (cond_level[i]),
            .rising_edge  (cond_rise[i]),
            .falling_edge (cond_fall[i])
        );
    end

    spi_protocol_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .sclk_rise   (cond_rise[SCLK_IDX]),
        .sclk_fall   (cond_fall[SCLK_IDX]),
        .cs_level    (cond_level[CS_IDX]),
        .rw_flag     (parallel_out[0]),
        .shift_en    (shift_en),
        .addr_we     (addr_we),
        .load_en     (load_en),
        .mem_we      (mem_we),
        .miso_update (miso_update),
        .miso_oe     (miso_oe)
    );

    shift_register u_shift (
        .clk          (clk),
        .reset        (reset),
        .shift_en     (shift_en),
        .serial_in    (cond_level[MOSI_IDX]),
        .load_en      (load_en),
        .parallel_in  (read_data),
        .miso_update  (miso_update),
        .parallel_out (parallel_out),
        .miso         (miso)
    );

    // Flag bit dropped, upper seven bits are the address
    data_memory u_mem (
        .clk        (clk),
        .reset      (reset),
        .addr_we    (addr_we),
        .addr_in    (parallel_out[$bits(spi_byte_t)-1:1]),
        .mem_we     (mem_we),
        .write_data (parallel_out),
        .read_data  (read_data)
    );

endmodule

// File: verif/spi_memory_tb.sv
/*
 * Mode 0 SPI master driving the slave memory, with a reference memory model.
 * Only addresses written earlier in the run are read back.
 */
`timescale 1ns/1ps
`include "spi_memory_settings.svh"

module spi_memory_tb
    import spi_memory_pkg::*;
();
    localparam int DEPTH         = 2 ** `SPI_ADDR_WIDTH;
    localparam int HALF          = 16;              // clk cycles per SCLK phase
    localparam int GLITCH_CYCLES = 2;               // Shorter than COND_WAIT_TIME
    localparam int RESET_CYCLES  = 5;
    localparam int NUM_MIXED     = 40;
    localparam int NUM_TRANS     = NUM_MIXED + 4;   // Plus abort, glitch and their reads
    localparam int TIMEOUT_NS    = NUM_TRANS * 18 * 32 * 4 + 20000;

    // miso_oe expectation per clk cycle
    localparam logic [1:0] OE_LOW  = 2'd0;
    localparam logic [1:0] OE_HIGH = 2'd1;
    localparam logic [1:0] OE_ANY  = 2'd2;   // Conditioner latency window

    logic clk = 1'b0;
    logic reset;
    logic sclk;
    logic cs;
    logic mosi;
    logic miso;
    logic miso_oe;

    logic [1:0]  oe_rule;
    logic [31:0] rng_state = 32'd65207;
    int          checks = 0;
    int          errors = 0;
    spi_state_t  dbg_state;

    spi_byte_t ref_mem [DEPTH];     // Last completed write per address
    logic      ref_valid [DEPTH];
    spi_addr_t written_addrs [$];   // Addresses safe to read back

    always #2 clk = ~clk;           // 4 ns period

    assign dbg_state = dut.u_fsm.state;

    spi_memory dut (
        .clk     (clk),
        .reset   (reset),
        .sclk    (sclk),
        .cs      (cs),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    // --------------------
    // Random numbers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // --------------------
    // Output enable window
    // --------------------
    always @(negedge clk) begin
        if (!reset && oe_rule != OE_ANY) begin
            checks++;
            assert (miso_oe == (oe_rule == OE_HIGH)) else begin
                errors++;
                $display("** Error: miso_oe expected %h got %h, state %s at %0t ns",
                         (oe_rule == OE_HIGH), miso_oe, dbg_state.name(), $time);
            end
        end
    end

    // Pins must stay quiet after reset
    task automatic check_idle_pins(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checks++;
            assert (miso == 1'b0) else begin
                errors++;
                $display("** Error: miso expected %h got %h after reset", 1'b0, miso);
            end
        end
    endtask

    // One SCLK period, mosi set on the falling side, miso taken at the rise
    task automatic sclk_cycle(input logic bit_val, input logic glitch, output logic sampled);
        mosi <= bit_val;
        repeat (HALF) @(posedge clk);
        sclk    <= 1'b1;
        sampled = miso;                 // Last changed about ten cycles ago
        if (glitch) begin
            mosi <= !bit_val;           // Lands on the sample point if it got through
            repeat (GLITCH_CYCLES) @(posedge clk);
            mosi <= bit_val;
            repeat (HALF - GLITCH_CYCLES) @(posedge clk);
        end else begin
            repeat (HALF) @(posedge clk);
        end
        sclk <= 1'b0;
    endtask

    // --------------------
    // Bus transactions
    // --------------------
    task automatic spi_transfer(input logic [15:0] frame, input int n_bits,
                                input logic is_read, input int glitch_bit,
                                output spi_byte_t rx);
        logic sampled;
        rx = '0;
        @(posedge clk);
        cs <= 1'b0;
        repeat (HALF) @(posedge clk);   // cs setup
        for (int i = 0; i < n_bits; i++) begin
            if (is_read && i == 7) begin
                oe_rule <= OE_ANY;      // Flag bit, enable may rise
            end
            sclk_cycle(frame[15-i], (i == glitch_bit), sampled);
            if (i >= 8) begin
                rx = {rx[6:0], sampled};   // MSB first
            end
            if (is_read && i == 7) begin
                oe_rule <= OE_HIGH;
            end
        end
        repeat (HALF) @(posedge clk);
        cs <= 1'b1;
        if (is_read) begin
            oe_rule <= OE_ANY;          // Drops a few cycles after cs
        end
        repeat (HALF) @(posedge clk);
        oe_rule <= OE_LOW;
    endtask

    task automatic write_byte(input spi_addr_t addr, input spi_byte_t data,
                              input int glitch_bit);
        spi_byte_t rx;
        spi_transfer({addr, 1'b0, data}, 16, 1'b0, glitch_bit, rx);
        ref_mem[addr] = data;
        if (!ref_valid[addr]) begin
            ref_valid[addr] = 1'b1;
            written_addrs.push_back(addr);
        end
    endtask

    // cs rises after 12 of 16 bits, memory keeps its byte
    task automatic abort_write(input spi_addr_t addr, input spi_byte_t data);
        spi_byte_t rx;
        spi_transfer({addr, 1'b0, data}, 12, 1'b0, -1, rx);
    endtask

    task automatic read_and_check(input spi_addr_t addr);
        spi_byte_t rx;
        spi_transfer({addr, 1'b1, 8'h00}, 16, 1'b1, -1, rx);
        checks++;
        assert (rx == ref_mem[addr]) else begin
            errors++;
            $display("** Error: miso read at address %h expected %h got %h",
                     addr, ref_mem[addr], rx);
        end
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, transactions did not finish", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        logic [31:0] r;
        spi_addr_t   addr;
        spi_byte_t   data;
        int          idx;
        reset   = 1'b1;
        sclk    = 1'b0;
        cs      = 1'b1;
        mosi    = 1'b0;
        oe_rule = OE_LOW;
        foreach (ref_valid[a]) begin
            ref_valid[a] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_idle_pins(20);            // Also lets conditioned cs settle high

        // Mixed writes and reads, first one always a write
        for (int n = 0; n < NUM_MIXED; n++) begin
            r = next_random();
            if (written_addrs.size() == 0 || r[0] == 1'b0) begin
                addr = spi_addr_t'(r[14:8]);
                data = r[23:16];
                write_byte(addr, data, -1);
            end else begin
                idx = int'(r[31:16]) % written_addrs.size();
                read_and_check(written_addrs[idx]);
            end
        end

        // Aborted write to a known address
        r    = next_random();
        idx  = int'(r[31:16]) % written_addrs.size();
        addr = written_addrs[idx];
        abort_write(addr, ~ref_mem[addr]);
        read_and_check(addr);

        // Short mosi glitch on data bit 4
        r    = next_random();
        addr = spi_addr_t'(r[14:8]);
        data = r[23:16];
        write_byte(addr, data, 11);
        read_and_check(addr);

        repeat (HALF) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: spi_memory.f
+incdir+common
common/spi_memory_pkg.sv
source/input_conditioner.sv
source/shift_register.sv
source/data_memory.sv
source/spi_protocol_fsm.sv
source/spi_memory.sv
verif/spi_memory_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SPI slave memory testbench with Verilator and runs it into a log file
set -e
cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module spi_memory_tb \
    --Mdir "$BUILD_DIR" \
    -o Vspi_memory_tb \
    -f spi_memory.f

run_status=0
"./$BUILD_DIR/Vspi_memory_tb" > "$LOG" 2>&1 || run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG" || [ "$run_status" -ne 0 ]; then
    echo "FAIL: see $LOG"
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "FAIL: run ended without a result, see $LOG"
    exit 1
fi
echo "PASS"
